// File: pcpu.f
+incdir+rtl
rtl/pcpu_isa_pkg.sv
rtl/pcpu_pipe_pkg.sv
rtl/pcpu_decoder.sv
rtl/pcpu_regfile.sv
rtl/pcpu_alu.sv
rtl/pcpu_hazard.sv
rtl/pcpu_cp0.sv
rtl/pcpu.sv
testbench/pcpu_assertions.sv
testbench/tb_pcpu.sv

// File: Bender.yml
package:
  name: pcpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pcpu_isa_pkg.sv
      - rtl/pcpu_pipe_pkg.sv
      - rtl/pcpu_decoder.sv
      - rtl/pcpu_regfile.sv
      - rtl/pcpu_alu.sv
      - rtl/pcpu_hazard.sv
      - rtl/pcpu_cp0.sv
      - rtl/pcpu.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/pcpu_assertions.sv
      - testbench/tb_pcpu.sv

// File: testbench/tb_pcpu.sv
`timescale 1ns/1ns
`include "pcpu_cfg.svh"

module tb_pcpu;
	import pcpu_isa_pkg::*;

	localparam int    MAX_CYCLES = 4000;           // five programs under 150 cycles each, with margin
	localparam word_t SENTINEL   = 32'h0000_0ffc;  // last store of every program
	localparam word_t NOP        = 32'h0000_0025;  // or $0,$0,$0
	localparam word_t RES_BASE   = 32'h0000_0400;  // results land here upward

	logic                       clk;
	logic                       rst_n;
	logic [`PCPU_IRQ_LINES-1:0] irq;
	word_t                      inst_data;
	word_t                      mem_data_in;
	word_t                      inst_addr;
	word_t                      mem_addr;
	word_t                      mem_data;
	logic                       mem_we;

	word_t imem [256];
	word_t dmem [1024];
	word_t got_addr [$];
	word_t got_data [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t asm_pc;        // assembly cursor
	word_t st_ptr;        // next result address
	logic  done;
	int    cycles = 0;
	int    errors = 0;

	pcpu i_pcpu (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_data   (inst_data),
		.mem_data_in (mem_data_in),
		.irq         (irq),
		.inst_addr   (inst_addr),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_we      (mem_we)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////
	// memories, both combinational read
	//////////////////////////////////////////////////

	assign inst_data   = imem[inst_addr[9:2]];
	assign mem_data_in = dmem[mem_addr[11:2]];

	always @(posedge clk) begin
		if (rst_n && mem_we) dmem[mem_addr[11:2]] <= mem_data;
	end

	// store log, sampled mid cycle
	always @(negedge clk) begin
		if (rst_n && mem_we) begin
			got_addr.push_back(mem_addr);
			got_data.push_back(mem_data);
			if (mem_addr == SENTINEL) done = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, a program never reached its final store", cycles);
			$display("Some tests failed");
			$fatal(1, "cycle limit reached");
		end
	end

	//////////////////////////////////////////////////
	// encoders and program helpers
	//////////////////////////////////////////////////

	function automatic word_t fill_word(input int idx);
		return 32'h5a00_0000 ^ (idx * 32'h0001_0003);  // every address differs
	endfunction

	function automatic word_t enc_r(input reg_idx_t rs, rt, rd, input funct_t fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t enc_i(input opcode_t op, input reg_idx_t rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_j(input word_t target);
		return {OP_J, target[27:2]};
	endfunction

	function automatic word_t enc_cop0(input reg_idx_t sub, gpr, sel);
		return {OP_COP0, sub, gpr, sel, 11'd0};
	endfunction

	// 30-bit signed value, add and sub of two never overflow
	function automatic word_t small_random();
		word_t r;
		r = $urandom();
		return {{2{r[29]}}, r[29:0]};
	endfunction

	task automatic emit(input word_t w);
		imem[asm_pc[9:2]] = w;
		asm_pc = asm_pc + 32'd4;
	endtask

	task automatic emit_const(input reg_idx_t r, input word_t v);
		emit(enc_i(OP_LUI, 5'd0, r, v[31:16]));
		emit(enc_i(OP_ORI, r, r, v[15:0]));
	endtask

	task automatic expect_store(input word_t addr, input word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic store_and_expect(input reg_idx_t r, input word_t value);
		emit(enc_i(OP_SW, 5'd0, r, st_ptr[15:0]));
		expect_store(st_ptr, value);
		st_ptr = st_ptr + 32'd4;
	endtask

	// handler stores epc then cause
	task automatic expect_handler(input word_t epc, input word_t cause);
		expect_store(32'h0000_0200, epc);
		expect_store(32'h0000_0204, cause);
	endtask

	task automatic emit_finish(input logic [15:0] id);
		emit(enc_i(OP_ORI, 5'd0, 5'd30, id));
		emit(enc_i(OP_SW, 5'd0, 5'd30, SENTINEL[15:0]));
		expect_store(SENTINEL, {16'h0000, id});
		emit(enc_j(asm_pc));  // park here
	endtask

	task automatic check(input string what, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			errors++;
			$display("Fail %0t: %s, got %h expected %h", $time, what, actual, expected);
			$display("Some tests failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic compare_stores(input string name);
		check({name, " store count"}, got_addr.size(), exp_addr.size());
		for (int i = 0; i < exp_addr.size(); i++) begin
			check($sformatf("%s store %0d address", name, i), got_addr[i], exp_addr[i]);
			check($sformatf("%s store %0d data", name, i), got_data[i], exp_data[i]);
		end
	endtask

	//////////////////////////////////////////////////
	// reset, load, run
	//////////////////////////////////////////////////

	task automatic begin_program();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		irq   = '0;
		done  = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = NOP;
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = fill_word(i);
		end
		got_addr.delete();
		got_data.delete();
		exp_addr.delete();
		exp_data.delete();
		st_ptr = RES_BASE;
		asm_pc = `PCPU_EXC_VECTOR;
		emit(enc_cop0(COP0_MF, 5'd26, CP0_EPC));
		emit(enc_cop0(COP0_MF, 5'd27, CP0_CAUSE));
		emit(enc_i(OP_SW, 5'd0, 5'd26, 16'h0200));
		emit(enc_i(OP_SW, 5'd0, 5'd27, 16'h0204));
		emit(enc_i(OP_ANDI, 5'd27, 5'd27, 16'h007c));  // exccode field
		emit(enc_i(OP_BEQ, 5'd27, 5'd0, 16'd1));        // interrupt resumes at epc itself
		emit(enc_i(OP_ADDI, 5'd26, 5'd26, 16'd4));
		emit(enc_cop0(COP0_MT, 5'd26, CP0_EPC));
		emit(enc_cop0(COP0_MT, 5'd0, CP0_STATUS));      // ie off, no re-entry on return
		emit({OP_COP0, COP0_CO, 15'd0, FN_ERET});
		asm_pc = `PCPU_RESET_PC;
	endtask

	task automatic release_reset();
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic wait_sentinel();
		while (!done) begin
			@(posedge clk);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic arith_test();
		word_t       a;
		word_t       b;
		logic [15:0] imm;
		begin_program();
		a   = small_random();
		b   = small_random();
		imm = $urandom();
		emit_const(5'd1, a);
		emit_const(5'd2, b);
		emit(enc_r(5'd1, 5'd2, 5'd3, FN_ADD));
		store_and_expect(5'd3, a + b);
		emit(enc_r(5'd1, 5'd2, 5'd3, FN_ADDU));
		store_and_expect(5'd3, a + b);
		emit(enc_r(5'd1, 5'd2, 5'd3, FN_SUB));
		store_and_expect(5'd3, a - b);
		emit(enc_r(5'd1, 5'd2, 5'd3, FN_AND));
		store_and_expect(5'd3, a & b);
		emit(enc_r(5'd1, 5'd2, 5'd3, FN_OR));
		store_and_expect(5'd3, a | b);
		emit(enc_r(5'd1, 5'd2, 5'd3, FN_SLT));
		store_and_expect(5'd3, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		emit(enc_r(5'd2, 5'd1, 5'd3, FN_SLT));  // operands swapped
		store_and_expect(5'd3, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		emit(enc_i(OP_ADDI, 5'd1, 5'd3, imm));
		store_and_expect(5'd3, a + {{16{imm[15]}}, imm});
		emit(enc_i(OP_ANDI, 5'd1, 5'd3, imm));
		store_and_expect(5'd3, a & {16'h0000, imm});
		emit(enc_i(OP_ORI, 5'd1, 5'd3, imm));
		store_and_expect(5'd3, a | {16'h0000, imm});
		emit(enc_i(OP_LUI, 5'd0, 5'd3, imm));
		store_and_expect(5'd3, {imm, 16'h0000});
		emit_finish(16'd1);
		release_reset();
		wait_sentinel();
		compare_stores("arithmetic");
	endtask

	task automatic forward_test();
		word_t x;
		word_t y;
		word_t v3;
		word_t v4;
		word_t v5;
		word_t v6;
		begin_program();
		x  = $urandom();
		y  = $urandom();
		v3 = x + y;
		v4 = v3 + x;
		v5 = v4 | v3;
		v6 = v5 & v4;
		emit_const(5'd1, x);
		emit_const(5'd2, y);
		emit(enc_r(5'd1, 5'd2, 5'd3, FN_ADDU));
		emit(enc_r(5'd3, 5'd1, 5'd4, FN_ADDU));  // from ex/mem
		emit(enc_r(5'd4, 5'd3, 5'd5, FN_OR));    // ex/mem and mem/wb
		emit(enc_r(5'd5, 5'd4, 5'd6, FN_AND));
		store_and_expect(5'd6, v6);             // lands at RES_BASE
		store_and_expect(5'd5, v5);
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h0500));
		expect_store(32'h0000_0500, x);
		emit(enc_i(OP_LW, 5'd0, 5'd7, 16'h0500));
		emit(enc_r(5'd7, 5'd2, 5'd8, FN_ADDU));  // load-use, one bubble
		store_and_expect(5'd8, x + y);
		emit(enc_i(OP_LW, 5'd0, 5'd9, 16'h0600));
		store_and_expect(5'd9, fill_word(32'h600 >> 2));  // load into store data
		emit(enc_i(OP_LW, 5'd0, 5'd10, RES_BASE[15:0]));
		emit(enc_r(5'd10, 5'd10, 5'd11, FN_ADDU));
		store_and_expect(5'd11, v6 + v6);
		emit(enc_r(5'd1, 5'd1, 5'd12, FN_ADDU));
		emit(NOP);
		emit(NOP);
		store_and_expect(5'd12, x + x);         // regfile bypass
		emit_finish(16'd2);
		release_reset();
		wait_sentinel();
		compare_stores("forwarding");
	endtask

	task automatic branch_test();
		begin_program();
		emit(enc_i(OP_ORI, 5'd0, 5'd1, 16'd5));
		emit(enc_i(OP_ORI, 5'd0, 5'd2, 16'd5));
		emit(enc_i(OP_ORI, 5'd0, 5'd3, 16'd7));
		emit(enc_i(OP_BEQ, 5'd1, 5'd2, 16'd2));  // taken
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h07f0));  // wrong path
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h07f0));  // wrong path
		store_and_expect(5'd2, 32'd5);
		emit(enc_i(OP_BEQ, 5'd1, 5'd3, 16'd1));  // not taken
		store_and_expect(5'd3, 32'd7);
		emit(enc_j(asm_pc + 32'd8));
		emit(enc_i(OP_SW, 5'd0, 5'd3, 16'h07f4));  // skipped by j
		emit(enc_i(OP_ORI, 5'd0, 5'd4, 16'd9));
		store_and_expect(5'd4, 32'd9);
		emit_finish(16'd3);
		release_reset();
		wait_sentinel();
		compare_stores("control flow");
	endtask

	task automatic exception_test();
		word_t p;
		begin_program();
		emit_const(5'd1, 32'h7fff_ffff);
		emit(enc_i(OP_ORI, 5'd0, 5'd2, 16'd1));
		emit(enc_i(OP_ORI, 5'd0, 5'd5, 16'h1234));
		p = asm_pc;
		emit(enc_r(5'd1, 5'd2, 5'd5, FN_ADD));  // max positive + 1
		expect_handler(p, 32'd12 << 2);
		store_and_expect(5'd5, 32'h0000_1234);  // old value kept
		p = asm_pc;
		emit({6'h00, 20'd0, FN_SYSCALL});
		expect_handler(p, 32'd8 << 2);
		p = asm_pc;
		emit(32'hfc00_0000);  // opcode 0x3f
		expect_handler(p, 32'd10 << 2);
		store_and_expect(5'd2, 32'd1);
		emit_finish(16'd4);
		release_reset();
		wait_sentinel();
		compare_stores("exceptions");
	endtask

	task automatic interrupt_test();
		int    k;
		word_t p;
		word_t status;
		begin_program();
		k      = $urandom_range(`PCPU_IRQ_LINES - 1, 0);
		status = (32'd1 << (10 + k)) | 32'd1;  // mask bit and ie
		emit(enc_i(OP_ORI, 5'd0, 5'd1, 16'h0055));
		store_and_expect(5'd1, 32'h0000_0055);  // irq already high, ie still 0
		emit_const(5'd2, status);
		emit(enc_cop0(COP0_MT, 5'd2, CP0_STATUS));
		p = asm_pc;
		emit(enc_i(OP_ORI, 5'd0, 5'd3, 16'h0066));  // interrupted, then replayed
		expect_handler(p, 32'd1 << (10 + k));
		store_and_expect(5'd3, 32'h0000_0066);
		emit_finish(16'd5);
		release_reset();
		irq[k] = 1'b1;
		wait_sentinel();
		compare_stores("interrupt");
		irq = '0;
	endtask

	//////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(82938));
		rst_n  = 1'b0;
		irq    = '0;
		done   = 1'b0;
		asm_pc = `PCPU_RESET_PC;
		st_ptr = RES_BASE;
		arith_test();
		forward_test();
		branch_test();
		exception_test();
		interrupt_test();
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: testbench/pcpu_assertions.sv
`timescale 1ns/1ns
`include "pcpu_cfg.svh"

module pcpu_assertions (
	input logic                clk,
	input logic                rst_n,
	input pcpu_isa_pkg::word_t inst_addr,
	input pcpu_isa_pkg::word_t mem_addr,
	input logic                mem_we
);

	//////////////////////////////////////////////////
	// port rules
	//////////////////////////////////////////////////

	// reset is synchronous, so mem stage is empty from the second reset edge on
	no_store_in_reset: assert property (@(posedge clk) (!rst_n ##1 !rst_n) |-> !mem_we)
		else $error("store strobe seen while reset held");

	fetch_aligned: assert property (@(posedge clk) rst_n |-> inst_addr[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	store_aligned: assert property (@(posedge clk) (rst_n && mem_we) |-> mem_addr[1:0] == 2'b00)
		else $error("store address not word aligned");

	// first fetch after release
	reset_fetch: assert property (@(posedge clk) $rose(rst_n) |-> inst_addr == `PCPU_RESET_PC)
		else $error("first fetch after reset not at reset pc");

endmodule

bind pcpu pcpu_assertions i_pcpu_assertions (
	.clk       (clk),
	.rst_n     (rst_n),
	.inst_addr (inst_addr),
	.mem_addr  (mem_addr),
	.mem_we    (mem_we)
);

// File: rtl/pcpu.sv
`timescale 1ns/1ns
`include "pcpu_cfg.svh"

module pcpu (
	input  logic                       clk,
	input  logic                       rst_n,
	input  pcpu_isa_pkg::word_t        inst_data,
	input  pcpu_isa_pkg::word_t        mem_data_in,
	input  logic [`PCPU_IRQ_LINES-1:0] irq,
	output pcpu_isa_pkg::word_t        inst_addr,
	output pcpu_isa_pkg::word_t        mem_addr,
	output pcpu_isa_pkg::word_t        mem_data,
	output logic                       mem_we
);
	import pcpu_isa_pkg::*;
	import pcpu_pipe_pkg::*;

	word_t    pc_q;
	if_id_t   if_id_q;
	id_ex_t   id_ex_q;
	ex_mem_t  ex_mem_q;
	mem_wb_t  mem_wb_q;

	ctrl_t    id_ctrl;
	word_t    id_inst;
	word_t    id_rs_data;
	word_t    id_rt_data;
	word_t    id_imm;
	word_t    jmp_target;
	id_ex_t   id_ex_d;
	logic     id_uses_rt;
	logic     jmp_taken;
	logic     hz_stall;
	logic     stall;

	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	word_t    ex_a;
	word_t    ex_b_reg;  // forwarded rt
	word_t    alu_y;
	word_t    br_target;
	logic     alu_ovf;
	logic     br_taken;

	word_t    mem_result;
	word_t    cp0_rd;
	word_t    redirect_pc;
	logic     take_exc;
	logic     cp0_redirect;
	logic     ovf_trap;
	logic     mem_fwd_we;
	mem_wb_t  mem_wb_d;
	logic     wb_we;

	//////////////////////////////////////////////////
	// if
	//////////////////////////////////////////////////

	assign inst_addr = pc_q;

	always_ff @(posedge clk) begin
		if (!rst_n) pc_q <= `PCPU_RESET_PC;
		else if (cp0_redirect) pc_q <= redirect_pc;  // oldest redirect first
		else if (br_taken) pc_q <= br_target;
		else if (jmp_taken) pc_q <= jmp_target;
		else if (!stall) pc_q <= pc_q + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || cp0_redirect || br_taken || jmp_taken) begin
			if_id_q.valid <= 1'b0;  // wrong path
		end else if (!stall) begin
			if_id_q.valid <= 1'b1;
			if_id_q.pc    <= pc_q;
			if_id_q.inst  <= inst_data;
		end
	end

	//////////////////////////////////////////////////
	// id
	//////////////////////////////////////////////////

	assign id_inst    = if_id_q.inst;
	assign id_imm     = id_ctrl.sign_ext ? {{16{id_inst[15]}}, id_inst[15:0]}
		: {16'h0000, id_inst[15:0]};
	assign jmp_target = {if_id_q.pc[31:28], id_inst[25:0], 2'b00};
	assign id_uses_rt = !id_ctrl.use_imm || id_ctrl.mem_wr;  // sw reads rt too
	assign stall      = hz_stall && if_id_q.valid;
	assign jmp_taken  = if_id_q.valid && id_ctrl.jump && !stall;

	pcpu_decoder i_decoder (
		.inst (id_inst),
		.ctrl (id_ctrl)
	);

	pcpu_regfile i_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_idx  (if_id_q.inst.rs),
		.rt_idx  (if_id_q.inst.rt),
		.we      (wb_we),
		.wr_idx  (mem_wb_q.dst),
		.wr_data (mem_wb_q.data),
		.rs_data (id_rs_data),
		.rt_data (id_rt_data)
	);

	always_comb begin
		id_ex_d.valid   = if_id_q.valid;
		id_ex_d.pc      = if_id_q.pc;
		id_ex_d.ctrl    = id_ctrl;
		id_ex_d.rs      = if_id_q.inst.rs;
		id_ex_d.rt      = if_id_q.inst.rt;
		id_ex_d.dst     = id_ctrl.dst_rd ? if_id_q.inst.rd : if_id_q.inst.rt;
		id_ex_d.cp0_sel = if_id_q.inst.rd;  // cp0 number for mfc0/mtc0
		id_ex_d.rs_data = id_rs_data;
		id_ex_d.rt_data = id_rt_data;
		id_ex_d.imm     = id_imm;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || cp0_redirect || br_taken || stall) id_ex_q.valid <= 1'b0;  // bubble
		else id_ex_q <= id_ex_d;
	end

	//////////////////////////////////////////////////
	// ex
	//////////////////////////////////////////////////

	pcpu_hazard i_hazard (
		.id_rs      (if_id_q.inst.rs),
		.id_rt      (if_id_q.inst.rt),
		.id_uses_rt (id_uses_rt),
		.ex_rs      (id_ex_q.rs),
		.ex_rt      (id_ex_q.rt),
		.ex_is_load (id_ex_q.valid && id_ex_q.ctrl.mem_rd),
		.ex_rd      (id_ex_q.dst),
		.mem_rd     (ex_mem_q.dst),
		.mem_we     (mem_fwd_we),
		.wb_rd      (mem_wb_q.dst),
		.wb_we      (wb_we),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.stall      (hz_stall)
	);

	always_comb begin
		case (fwd_a)
			FWD_EXMEM: ex_a = mem_result;
			FWD_MEMWB: ex_a = mem_wb_q.data;
			default:   ex_a = id_ex_q.rs_data;
		endcase
		case (fwd_b)
			FWD_EXMEM: ex_b_reg = mem_result;
			FWD_MEMWB: ex_b_reg = mem_wb_q.data;
			default:   ex_b_reg = id_ex_q.rt_data;
		endcase
	end

	pcpu_alu i_alu (
		.op  (id_ex_q.ctrl.alu_op),
		.a   (ex_a),
		.b   (id_ex_q.ctrl.use_imm ? id_ex_q.imm : ex_b_reg),
		.y   (alu_y),
		.ovf (alu_ovf)
	);

	// beq decided here and two younger slots dropped
	assign br_taken  = id_ex_q.valid && id_ex_q.ctrl.branch && (ex_a == ex_b_reg);
	assign br_target = id_ex_q.pc + 32'd4 + {id_ex_q.imm[29:0], 2'b00};

	always_ff @(posedge clk) begin
		if (!rst_n || cp0_redirect) begin
			ex_mem_q.valid <= 1'b0;
		end else begin
			ex_mem_q.valid      <= id_ex_q.valid;
			ex_mem_q.pc         <= id_ex_q.pc;
			ex_mem_q.ctrl       <= id_ex_q.ctrl;
			ex_mem_q.dst        <= id_ex_q.dst;
			ex_mem_q.cp0_sel    <= id_ex_q.cp0_sel;
			ex_mem_q.result     <= alu_y;
			ex_mem_q.store_data <= ex_b_reg;
			ex_mem_q.ovf        <= alu_ovf;
		end
	end

	//////////////////////////////////////////////////
	// mem / wb
	//////////////////////////////////////////////////

	assign ovf_trap   = ex_mem_q.valid && ex_mem_q.ctrl.ovf_trap && ex_mem_q.ovf;
	assign mem_fwd_we = ex_mem_q.valid && ex_mem_q.ctrl.reg_we;
	assign mem_result = ex_mem_q.ctrl.mfc0 ? cp0_rd : ex_mem_q.result;

	pcpu_cp0 i_cp0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.irq         (irq),
		.mem_stage   (ex_mem_q),
		.ovf_trap    (ovf_trap),
		.take_exc    (take_exc),
		.redirect    (cp0_redirect),
		.redirect_pc (redirect_pc),
		.rd_data     (cp0_rd)
	);

	// faulting instruction is cancelled along with the younger ones
	assign mem_we   = ex_mem_q.valid && ex_mem_q.ctrl.mem_wr && !take_exc;
	assign mem_addr = ex_mem_q.result;
	assign mem_data = ex_mem_q.store_data;

	always_comb begin
		mem_wb_d.valid  = ex_mem_q.valid && !take_exc;
		mem_wb_d.reg_we = ex_mem_q.ctrl.reg_we;
		mem_wb_d.dst    = ex_mem_q.dst;
		mem_wb_d.data   = ex_mem_q.ctrl.mem_rd ? mem_data_in : mem_result;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) mem_wb_q.valid <= 1'b0;
		else mem_wb_q <= mem_wb_d;
	end

	assign wb_we = mem_wb_q.valid && mem_wb_q.reg_we;

endmodule

// File: rtl/pcpu_cp0.sv
`timescale 1ns/1ns
`include "pcpu_cfg.svh"

module pcpu_cp0 (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`PCPU_IRQ_LINES-1:0]  irq,
	input  pcpu_pipe_pkg::ex_mem_t      mem_stage,
	input  logic                        ovf_trap,
	output logic                        take_exc,
	output logic                        redirect,
	output pcpu_isa_pkg::word_t         redirect_pc,
	output pcpu_isa_pkg::word_t         rd_data
);
	import pcpu_isa_pkg::*;

	logic                       ie;
	logic                       exl;
	logic [`PCPU_IRQ_LINES-1:0] im;
	logic [`PCPU_IRQ_LINES-1:0] ip;        // cause.ip, follows irq
	exc_code_t                  exc_code;
	word_t                      epc;
	exc_code_t                  cause_d;
	logic                       int_pend;
	logic                       eret_go;
	logic                       mtc0_go;
	word_t                      status_word;
	word_t                      cause_word;

	//////////////////////////////////////////////////
	// recognition, instruction in mem only
	//////////////////////////////////////////////////

	assign int_pend = mem_stage.valid && ie && !exl && |(irq & im);
	assign take_exc = int_pend || ovf_trap ||
		(mem_stage.valid && (mem_stage.ctrl.reserved || mem_stage.ctrl.syscall));
	assign eret_go  = mem_stage.valid && mem_stage.ctrl.eret && !take_exc;
	assign mtc0_go  = mem_stage.valid && mem_stage.ctrl.mtc0 && !take_exc;

	always_comb begin
		if (int_pend) cause_d = EXC_INT;  // interrupt ranks first
		else if (mem_stage.ctrl.reserved) cause_d = EXC_RI;
		else if (mem_stage.ctrl.syscall) cause_d = EXC_SYS;
		else cause_d = EXC_OV;
	end

	assign redirect    = take_exc || eret_go;
	assign redirect_pc = take_exc ? `PCPU_EXC_VECTOR : epc;

	//////////////////////////////////////////////////
	// state
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ie       <= 1'b0;
			exl      <= 1'b0;
			im       <= '0;
			ip       <= '0;
			exc_code <= EXC_INT;
		end else begin
			ip <= irq;
			if (take_exc) begin
				exl      <= 1'b1;  // masks further interrupts
				exc_code <= cause_d;
			end else if (eret_go) begin
				exl <= 1'b0;
			end else if (mtc0_go && mem_stage.cp0_sel == CP0_STATUS) begin
				im  <= mem_stage.store_data[10 +: `PCPU_IRQ_LINES];
				exl <= mem_stage.store_data[1];
				ie  <= mem_stage.store_data[0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_exc) begin
			epc <= mem_stage.pc;  // faulting or interrupted pc
		end else if (mtc0_go && mem_stage.cp0_sel == CP0_EPC) begin
			epc <= mem_stage.store_data;
		end
	end

	// mfc0 read port
	always_comb begin
		status_word                            = '0;
		status_word[10 +: `PCPU_IRQ_LINES]     = im;
		status_word[1]                         = exl;
		status_word[0]                         = ie;
		cause_word                             = '0;
		cause_word[10 +: `PCPU_IRQ_LINES]      = ip;
		cause_word[6:2]                        = exc_code;
		case (mem_stage.cp0_sel)
			CP0_STATUS: rd_data = status_word;
			CP0_CAUSE:  rd_data = cause_word;
			CP0_EPC:    rd_data = epc;
			default:    rd_data = '0;
		endcase
	end

endmodule

// File: rtl/pcpu_hazard.sv
`timescale 1ns/1ns

module pcpu_hazard (
	input  pcpu_isa_pkg::reg_idx_t  id_rs,
	input  pcpu_isa_pkg::reg_idx_t  id_rt,
	input  logic                    id_uses_rt,
	input  pcpu_isa_pkg::reg_idx_t  ex_rs,
	input  pcpu_isa_pkg::reg_idx_t  ex_rt,
	input  logic                    ex_is_load,
	input  pcpu_isa_pkg::reg_idx_t  ex_rd,
	input  pcpu_isa_pkg::reg_idx_t  mem_rd,
	input  logic                    mem_we,
	input  pcpu_isa_pkg::reg_idx_t  wb_rd,
	input  logic                    wb_we,
	output pcpu_pipe_pkg::fwd_sel_t fwd_a,
	output pcpu_pipe_pkg::fwd_sel_t fwd_b,
	output logic                    stall
);
	import pcpu_isa_pkg::*;
	import pcpu_pipe_pkg::*;

	// youngest producer wins and $0 is never forwarded
	function automatic fwd_sel_t pick(
		input reg_idx_t src,
		input reg_idx_t m_rd,
		input logic     m_we,
		input reg_idx_t w_rd,
		input logic     w_we
	);
		if (src == '0) begin
			return FWD_RF;
		end else if (m_we && m_rd == src) begin
			return FWD_EXMEM;
		end else if (w_we && w_rd == src) begin
			return FWD_MEMWB;
		end
		return FWD_RF;
	endfunction

	assign fwd_a = pick(ex_rs, mem_rd, mem_we, wb_rd, wb_we);
	assign fwd_b = pick(ex_rt, mem_rd, mem_we, wb_rd, wb_we);

	// load data only exists in mem so the consumer waits one cycle
	assign stall = ex_is_load && (ex_rd != '0) &&
		((ex_rd == id_rs) || (id_uses_rt && ex_rd == id_rt));

endmodule

// File: rtl/pcpu_alu.sv
`timescale 1ns/1ns

module pcpu_alu (
	input  pcpu_pipe_pkg::alu_op_t op,
	input  pcpu_isa_pkg::word_t    a,
	input  pcpu_isa_pkg::word_t    b,
	output pcpu_isa_pkg::word_t    y,
	output logic                   ovf
);
	import pcpu_isa_pkg::*;
	import pcpu_pipe_pkg::*;

	word_t sum;
	word_t diff;

	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		ovf = 1'b0;
		case (op)
			ALU_ADD: begin
				y   = sum;
				ovf = (a[31] == b[31]) && (sum[31] != a[31]);  // like signs, sign flipped
			end
			ALU_SUB: begin
				y   = diff;
				ovf = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};
			ALU_LUI: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

// File: rtl/pcpu_regfile.sv
`timescale 1ns/1ns

module pcpu_regfile (
	input  logic                  clk,
	input  logic                  rst_n,
	input  pcpu_isa_pkg::reg_idx_t rs_idx,
	input  pcpu_isa_pkg::reg_idx_t rt_idx,
	input  logic                  we,
	input  pcpu_isa_pkg::reg_idx_t wr_idx,
	input  pcpu_isa_pkg::word_t    wr_data,
	output pcpu_isa_pkg::word_t    rs_data,
	output pcpu_isa_pkg::word_t    rt_data
);
	import pcpu_isa_pkg::*;

	word_t regs [32];
	logic  wr_live;  // $0 never written

	assign wr_live = we && (wr_idx != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// wb result seen by id in the same cycle
	assign rs_data = (wr_live && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
	assign rt_data = (wr_live && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

// File: rtl/pcpu_decoder.sv
`timescale 1ns/1ns

module pcpu_decoder (
	input  pcpu_isa_pkg::word_t  inst,
	output pcpu_pipe_pkg::ctrl_t ctrl
);
	import pcpu_isa_pkg::*;
	import pcpu_pipe_pkg::*;

	inst_t   f;   // field view
	opcode_t op;
	funct_t  fn;

	assign f  = inst;
	assign op = opcode_t'(f.opcode);
	assign fn = funct_t'(f.funct);

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = ALU_ADD;
		case (op)
			OP_RTYPE: begin
				ctrl.dst_rd = 1'b1;
				ctrl.reg_we = 1'b1;
				case (fn)
					FN_ADD:  ctrl.ovf_trap = 1'b1;
					FN_ADDU: ctrl.alu_op = ALU_ADD;  // same adder, no trap
					FN_SUB: begin
						ctrl.alu_op   = ALU_SUB;
						ctrl.ovf_trap = 1'b1;
					end
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SYSCALL: begin
						ctrl.reg_we  = 1'b0;
						ctrl.syscall = 1'b1;
					end
					default: ctrl.reserved = 1'b1;
				endcase
			end
			OP_ADDI: begin
				ctrl.use_imm  = 1'b1;
				ctrl.sign_ext = 1'b1;
				ctrl.ovf_trap = 1'b1;
				ctrl.reg_we   = 1'b1;
			end
			OP_ANDI: begin
				ctrl.alu_op  = ALU_AND;
				ctrl.use_imm = 1'b1;  // zero extended
				ctrl.reg_we  = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op  = ALU_OR;
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			OP_LUI: begin
				ctrl.alu_op  = ALU_LUI;
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			OP_LW: begin
				ctrl.use_imm  = 1'b1;  // base + offset
				ctrl.sign_ext = 1'b1;
				ctrl.mem_rd   = 1'b1;
				ctrl.reg_we   = 1'b1;
			end
			OP_SW: begin
				ctrl.use_imm  = 1'b1;
				ctrl.sign_ext = 1'b1;
				ctrl.mem_wr   = 1'b1;
			end
			OP_BEQ: begin
				ctrl.branch   = 1'b1;
				ctrl.sign_ext = 1'b1;  // word offset
			end
			OP_J: ctrl.jump = 1'b1;
			OP_COP0: begin
				// sub-op lives in rs
				if (f.rs == COP0_MF) begin
					ctrl.mfc0   = 1'b1;
					ctrl.reg_we = 1'b1;  // into rt
				end else if (f.rs == COP0_MT) begin
					ctrl.mtc0 = 1'b1;
				end else if (f.rs == COP0_CO && fn == FN_ERET) begin
					ctrl.eret = 1'b1;
				end else begin
					ctrl.reserved = 1'b1;
				end
			end
			default: ctrl.reserved = 1'b1;
		endcase
		// unknown words leave no trace in state
		if (ctrl.reserved) begin
			ctrl.reg_we = 1'b0;
			ctrl.mem_wr = 1'b0;
		end
	end

endmodule

// File: rtl/pcpu_pipe_pkg.sv
package pcpu_pipe_pkg;
	import pcpu_isa_pkg::*;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI   // b[15:0] into upper half
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_RF,     // value read in id
		FWD_EXMEM,  // producer one ahead
		FWD_MEMWB   // producer two ahead
	} fwd_sel_t;

	//////////////////////////////////////////////////
	// decoded control
	//////////////////////////////////////////////////

	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;   // operand b from immediate
		logic    sign_ext;
		logic    ovf_trap;
		logic    reg_we;
		logic    mem_rd;
		logic    mem_wr;
		logic    branch;
		logic    jump;
		logic    mfc0;
		logic    mtc0;
		logic    eret;
		logic    syscall;
		logic    reserved;
		logic    dst_rd;    // rd when set, else rt
	} ctrl_t;

	//////////////////////////////////////////////////
	// stage registers
	//////////////////////////////////////////////////

	typedef struct packed {
		logic  valid;
		word_t pc;
		inst_t inst;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		ctrl_t    ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dst;
		reg_idx_t cp0_sel;
		word_t    rs_data;
		word_t    rt_data;
		word_t    imm;      // already extended
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		ctrl_t    ctrl;
		reg_idx_t dst;
		reg_idx_t cp0_sel;
		word_t    result;     // alu out, also mem address
		word_t    store_data; // forwarded rt, sw and mtc0
		logic     ovf;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		logic     reg_we;
		reg_idx_t dst;
		word_t    data;
	} mem_wb_t;

endpackage

// File: rtl/pcpu_isa_pkg.sv
package pcpu_isa_pkg;

	//////////////////////////////////////////////////
	// basic widths
	//////////////////////////////////////////////////

	typedef logic [31:0] word_t;     // data or address
	typedef logic [4:0]  reg_idx_t;  // gpr or cp0 number

	// instruction fields, r-type layout
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;  // unused by the subset
		logic [5:0] funct;
	} inst_t;

	//////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_COP0  = 6'h10,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SYSCALL = 6'h0c,
		FN_ERET    = 6'h18,  // cop0 co format
		FN_ADD     = 6'h20,
		FN_ADDU    = 6'h21,
		FN_SUB     = 6'h22,
		FN_AND     = 6'h24,
		FN_OR      = 6'h25,
		FN_SLT     = 6'h2a
	} funct_t;

	// rs field of cop0 instructions
	localparam reg_idx_t COP0_MF = 5'b00000;
	localparam reg_idx_t COP0_MT = 5'b00100;
	localparam reg_idx_t COP0_CO = 5'b10000;

	typedef enum logic [4:0] {
		EXC_INT = 5'd0,
		EXC_SYS = 5'd8,
		EXC_RI  = 5'd10,
		EXC_OV  = 5'd12
	} exc_code_t;

	typedef enum logic [4:0] {
		CP0_STATUS = 5'd12,
		CP0_CAUSE  = 5'd13,
		CP0_EPC    = 5'd14
	} cp0_reg_t;

endpackage

// File: rtl/pcpu_cfg.svh
`ifndef PCPU_CFG_SVH
`define PCPU_CFG_SVH

//////////////////////////////////////////////////
// core configuration
//////////////////////////////////////////////////

// first fetch after reset
`define PCPU_RESET_PC    32'h0000_0000

// common entry for every exception and interrupt
`define PCPU_EXC_VECTOR  32'h0000_0180

// external interrupt inputs, irq[k] maps to Status bit 10+k
`define PCPU_IRQ_LINES   6

`endif
